// ==== Makefile ====
# Verilator build, run and lint for the dual-port memory subsystem.

VERILATOR ?= verilator
TOP       ?= tb_dp_mem
RTL_TOP   ?= dp_mem_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only
RTL_SRCS  ?= hw/dp_mem_pkg.sv hw/mem_port_if.sv hw/dp_byte_ram.sv \
             hw/wb_mem_port.sv hw/dp_mem_top.sv
HEADERS   ?= hw/dp_mem_cfg.svh tb/tb_dp_mem_util.svh
SIM_SRCS  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SIM_SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+hw $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/dp_byte_ram.sv ====
// Four-stage pipelined dual-port RAM with byte-lane writes and a done tag per port.
`timescale 1ns/1ns
`include "dp_mem_cfg.svh"

module dp_byte_ram
    import dp_mem_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    mem_port_if.ram pa,
    mem_port_if.ram pb
);

    localparam int n_ports = 2;
    localparam int depth   = 1 << `MEM_ADDR_WIDTH;

    mem_word_u ram [depth];

    // Index 0 is port A, index 1 is port B.
    logic [n_ports-1:0] in_req;
    logic [n_ports-1:0] in_we;
    mem_addr_t          in_addr   [n_ports];
    mem_word_u          in_wdata  [n_ports];
    mem_sel_t           in_sel    [n_ports];

    // Stage 1, captured request.
    logic [n_ports-1:0] s1_valid;
    logic [n_ports-1:0] s1_we;
    mem_addr_t          s1_addr   [n_ports];
    mem_word_u          s1_wdata  [n_ports];
    mem_sel_t           s1_sel    [n_ports];

    // Stage 2, array read done.
    logic [n_ports-1:0] s2_valid;
    logic [n_ports-1:0] s2_we;
    mem_addr_t          s2_addr   [n_ports];
    mem_word_u          s2_wdata  [n_ports];
    mem_sel_t           s2_sel    [n_ports];
    mem_word_u          s2_rdata  [n_ports];

    // Stage 3, write landed.
    logic [n_ports-1:0] s3_valid;
    mem_word_u          s3_rdata  [n_ports];

    // Stage 4, output.
    logic [n_ports-1:0] s4_valid;
    mem_word_u          s4_rdata  [n_ports];

    // Presented to the ports.
    logic [n_ports-1:0] out_done;
    mem_word_u          out_rdata [n_ports];

    assign in_req[0]   = pa.req;
    assign in_we[0]    = pa.we;
    assign in_addr[0]  = pa.addr;
    assign in_wdata[0] = pa.wdata;
    assign in_sel[0]   = pa.sel;

    assign in_req[1]   = pb.req;
    assign in_we[1]    = pb.we;
    assign in_addr[1]  = pb.addr;
    assign in_wdata[1] = pb.wdata;
    assign in_sel[1]   = pb.sel;

    assign pa.rdata = out_rdata[0];
    assign pa.done  = out_done[0];
    assign pb.rdata = out_rdata[1];
    assign pb.done  = out_done[1];

    // Valid tags and write flags.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= '0;
            s1_we    <= '0;
            s2_valid <= '0;
            s2_we    <= '0;
            s3_valid <= '0;
            s4_valid <= '0;
            out_done <= '0;
        end else begin
            s1_valid <= in_req;
            s1_we    <= in_req & in_we;
            s2_valid <= s1_valid;
            s2_we    <= s1_we;
            s3_valid <= s2_valid;
            s4_valid <= s3_valid;
            out_done <= s4_valid;
        end
    end

    // Payload stages, loaded only behind a valid tag.
    always_ff @(posedge clk) begin
        for (int p = 0; p < n_ports; p++) begin
            if (in_req[p]) begin
                s1_addr[p]  <= in_addr[p];
                s1_wdata[p] <= in_wdata[p];
                s1_sel[p]   <= in_sel[p];
            end
            if (s1_valid[p]) begin
                s2_addr[p]  <= s1_addr[p];
                s2_wdata[p] <= s1_wdata[p];
                s2_sel[p]   <= s1_sel[p];
                // Read before this access's own write.
                s2_rdata[p] <= ram[s1_addr[p]];
            end
            if (s2_valid[p]) begin
                s3_rdata[p] <= s2_rdata[p];
            end
            if (s3_valid[p]) begin
                s4_rdata[p] <= s3_rdata[p];
            end
        end
    end

    // Lane writes; B comes last so it wins a collision.
    always_ff @(posedge clk) begin
        for (int p = 0; p < n_ports; p++) begin
            if (s2_we[p]) begin
                for (int l = 0; l < `MEM_LANES; l++) begin
                    if (s2_sel[p][l]) begin
                        ram[s2_addr[p]].lanes[l] <= s2_wdata[p].lanes[l];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int p = 0; p < n_ports; p++) begin
                out_rdata[p].word <= '0;
            end
        end else begin
            for (int p = 0; p < n_ports; p++) begin
                if (s4_valid[p]) begin
                    out_rdata[p] <= s4_rdata[p];
                end
            end
        end
    end

    for (genvar p = 0; p < n_ports; p++) begin : g_chk
        // Every completion traces back to a request.
        a_done_tag: assert property (@(posedge clk) disable iff (rst)
            out_done[p] |-> $past(in_req[p], 5));

        // A write must touch some lane.
        a_write_sel: assert property (@(posedge clk) disable iff (rst)
            in_req[p] && in_we[p] |-> |in_sel[p]);
    end

endmodule

// ==== hw/dp_mem_cfg.svh ====
// Dual-port memory widths shared by the package and the RAM.
`ifndef DP_MEM_CFG_SVH
`define DP_MEM_CFG_SVH

// Word width in bits, any multiple of 8.
`define MEM_DATA_WIDTH 32

// Word address width.
// 8 bits gives 256 words.
`define MEM_ADDR_WIDTH 8

// One byte lane per 8 data bits.
`define MEM_LANES (`MEM_DATA_WIDTH / 8)

`endif

// ==== hw/dp_mem_pkg.sv ====
// Dual-port memory types for the word, its address and its lane select.
`include "dp_mem_cfg.svh"

package dp_mem_pkg;

    // Word address into the array.
    typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // One select bit per byte lane.
    typedef logic [`MEM_LANES-1:0] mem_sel_t;

    // One memory word, seen whole or as byte lanes.
    typedef union packed {
        logic [`MEM_DATA_WIDTH-1:0]  word;
        logic [`MEM_LANES-1:0][7:0]  lanes;
    } mem_word_u;

endpackage

// ==== hw/dp_mem_top.sv ====
// Dual-port memory subsystem with two Wishbone classic slave ports over a pipelined RAM.
`timescale 1ns/1ns

module dp_mem_top
    import dp_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Port A.
    input  logic      a_cyc,
    input  logic      a_stb,
    input  logic      a_we,
    input  mem_addr_t a_adr,
    input  mem_word_u a_dat_w,
    input  mem_sel_t  a_sel,
    output mem_word_u a_dat_r,
    output logic      a_ack,

    // Port B.
    input  logic      b_cyc,
    input  logic      b_stb,
    input  logic      b_we,
    input  mem_addr_t b_adr,
    input  mem_word_u b_dat_w,
    input  mem_sel_t  b_sel,
    output mem_word_u b_dat_r,
    output logic      b_ack
);

    mem_port_if mem_a ();
    mem_port_if mem_b ();

    wb_mem_port port_a (
        .clk   (clk),
        .rst   (rst),
        .cyc   (a_cyc),
        .stb   (a_stb),
        .we    (a_we),
        .adr   (a_adr),
        .dat_w (a_dat_w),
        .sel   (a_sel),
        .dat_r (a_dat_r),
        .ack   (a_ack),
        .mem   (mem_a)
    );

    wb_mem_port port_b (
        .clk   (clk),
        .rst   (rst),
        .cyc   (b_cyc),
        .stb   (b_stb),
        .we    (b_we),
        .adr   (b_adr),
        .dat_w (b_dat_w),
        .sel   (b_sel),
        .dat_r (b_dat_r),
        .ack   (b_ack),
        .mem   (mem_b)
    );

    // Port B is the second RAM port, so it wins lane collisions.
    dp_byte_ram ram_core (
        .clk (clk),
        .rst (rst),
        .pa  (mem_a),
        .pb  (mem_b)
    );

endmodule

// ==== hw/mem_port_if.sv ====
// Memory port link carrying one request and its completion between adapter and RAM.
`timescale 1ns/1ns

interface mem_port_if
    import dp_mem_pkg::*;
();

    // Request side, a one-cycle pulse on req.
    logic      req;
    mem_addr_t addr;
    mem_word_u wdata;
    mem_sel_t  sel;
    logic      we;

    // Completion five cycles after req.
    mem_word_u rdata;
    logic      done;

    modport ctrl (
        output req,
        output addr,
        output wdata,
        output sel,
        output we,
        input  rdata,
        input  done
    );

    modport ram (
        input  req,
        input  addr,
        input  wdata,
        input  sel,
        input  we,
        output rdata,
        output done
    );

endinterface

// ==== hw/wb_mem_port.sv ====
// Wishbone classic slave adapter issuing one RAM request per bus cycle.
`timescale 1ns/1ns

module wb_mem_port
    import dp_mem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  mem_addr_t   adr,
    input  mem_word_u   dat_w,
    input  mem_sel_t    sel,
    output mem_word_u   dat_r,
    output logic        ack,
    mem_port_if.ctrl    mem
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_wait = 2'd1;
    localparam logic [1:0] st_ack  = 2'd2;

    logic [1:0] state;
    logic       start;

    // New transfer only from idle.
    assign start = (state == st_idle) && cyc && stb;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            mem.req    <= 1'b0;
            ack        <= 1'b0;
            dat_r.word <= '0;
        end else begin
            mem.req <= 1'b0;
            ack     <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        mem.req <= 1'b1;
                        state   <= st_wait;
                    end
                end
                st_wait: begin
                    if (mem.done) begin
                        ack   <= 1'b1;
                        dat_r <= mem.rdata;
                        state <= st_ack;
                    end
                end
                st_ack: begin
                    // Strobe still belongs to the finished cycle.
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Request payload, held steady by the master anyway.
    always_ff @(posedge clk) begin
        if (start) begin
            mem.addr  <= adr;
            mem.wdata <= dat_w;
            mem.sel   <= sel;
            mem.we    <= we;
        end
    end

    // A request is issued only on leaving idle.
    a_req_from_idle: assert property (@(posedge clk) disable iff (rst)
        mem.req |-> $past(state) == st_idle);

    // Master keeps cyc up until it sees ack.
    a_ack_in_cyc: assert property (@(posedge clk) disable iff (rst)
        ack |-> cyc);

    // RAM completes only the access we are waiting for.
    a_done_in_wait: assert property (@(posedge clk) disable iff (rst)
        mem.done |-> state == st_wait);

endmodule

// ==== sources.f ====
+incdir+hw
+incdir+tb
hw/dp_mem_pkg.sv
hw/mem_port_if.sv
hw/dp_byte_ram.sv
hw/wb_mem_port.sv
hw/dp_mem_top.sv
tb/tb_dp_mem.sv

// ==== tb/tb_dp_mem_util.svh ====
// Testbench helpers for the dual-port memory: random source, reference model and bus driver.
`ifndef TB_DP_MEM_UTIL_SVH
`define TB_DP_MEM_UTIL_SVH

logic [31:0]   lfsr_state;
logic [dw-1:0] model_mem [depth];

// Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit returned.
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

function automatic logic [dw-1:0] rand_word();
    logic [dw-1:0] w;
    for (int l = 0; l < lanes; l++) begin
        w[8*l +: 8] = 8'(rand_bits(8));
    end
    return w;
endfunction

// Lane select with at least one lane enabled.
function automatic mem_sel_t rand_sel();
    mem_sel_t s;
    s = mem_sel_t'(rand_bits(lanes));
    if (s == '0) begin
        s[0] = 1'b1;
    end
    return s;
endfunction

// Bytes enabled by sel come from the new word, the rest stay.
function automatic logic [dw-1:0] merge_lanes(input logic [dw-1:0] old_word,
                                              input logic [dw-1:0] new_word,
                                              input mem_sel_t lane_sel);
    logic [dw-1:0] w;
    w = old_word;
    for (int l = 0; l < lanes; l++) begin
        if (lane_sel[l]) begin
            w[8*l +: 8] = new_word[8*l +: 8];
        end
    end
    return w;
endfunction

// One Wishbone classic transfer on port p; edges counts from the sampled strobe to ack.
task automatic bus_xfer(input int p, input logic wr, input mem_addr_t addr,
                        input logic [dw-1:0] data, input mem_sel_t lane_sel,
                        output logic [dw-1:0] rdata, output int edges);
    @(posedge clk);
    #2;
    cyc[p] = 1'b1;
    stb[p] = 1'b1;
    we[p] = wr;
    adr[p] = addr;
    dat_w[p].word = data;
    sel[p] = lane_sel;
    edges = 0;
    @(posedge clk);
    #1;
    while (!ack[p]) begin
        edges++;
        @(posedge clk);
        #1;
    end
    rdata = dat_r[p].word;
    // Master sees ack on this edge and releases the bus.
    @(posedge clk);
    #1;
    check_value("ack pulse width", '0, dw'(ack[p]));
    #1;
    cyc[p] = 1'b0;
    stb[p] = 1'b0;
    we[p] = 1'b0;
endtask

// Transfer checked against the model, which it then updates.
task automatic port_op(input int p, input logic wr, input mem_addr_t addr,
                       input logic [dw-1:0] data, input mem_sel_t lane_sel);
    logic [dw-1:0] expected;
    logic [dw-1:0] got;
    int            edges;
    expected = model_mem[addr];
    if (wr) begin
        model_mem[addr] = merge_lanes(expected, data, lane_sel);
    end
    bus_xfer(p, wr, addr, data, lane_sel, got, edges);
    check_value($sformatf("port %0d dat_r at %h", p, addr), expected, got);
    check_value("edges to ack", dw'(6), dw'(edges));
endtask

`endif

// ==== tb/tb_dp_mem.sv ====
// Testbench for the dual-port memory with random Wishbone traffic checked against a model.
`timescale 1ns/1ns
`include "dp_mem_cfg.svh"

module tb_dp_mem
    import dp_mem_pkg::*;
();

    localparam int dw    = `MEM_DATA_WIDTH;
    localparam int aw    = `MEM_ADDR_WIDTH;
    localparam int lanes = `MEM_LANES;
    localparam int depth = 1 << aw;

    localparam logic [31:0] lfsr_seed = 32'h580d1f7f;
    localparam int n_word = 16;
    localparam int n_byte = 64;
    localparam int n_lat  = 8;
    localparam int n_dual = 64;
    localparam int n_coll = 16;
    localparam int total_txns =
        depth + 2 * n_word + 2 * n_byte + n_lat + 2 * n_dual + 3 * n_coll;
    localparam int watchdog_margin = 200;
    localparam int watchdog_cycles = total_txns * 10 + watchdog_margin;

    // Index 0 drives port A, index 1 port B.
    logic      clk = 1'b0;
    logic      rst;
    logic      cyc   [2];
    logic      stb   [2];
    logic      we    [2];
    mem_addr_t adr   [2];
    mem_word_u dat_w [2];
    mem_sel_t  sel   [2];
    mem_word_u dat_r [2];
    logic      ack   [2];
    string     test_name;

    always #10 clk = ~clk;

    dp_mem_top dut (
        .clk     (clk),
        .rst     (rst),
        .a_cyc   (cyc[0]),
        .a_stb   (stb[0]),
        .a_we    (we[0]),
        .a_adr   (adr[0]),
        .a_dat_w (dat_w[0]),
        .a_sel   (sel[0]),
        .a_dat_r (dat_r[0]),
        .a_ack   (ack[0]),
        .b_cyc   (cyc[1]),
        .b_stb   (stb[1]),
        .b_we    (we[1]),
        .b_adr   (adr[1]),
        .b_dat_w (dat_w[1]),
        .b_sel   (sel[1]),
        .b_dat_r (dat_r[1]),
        .b_ack   (ack[1])
    );

    `include "tb_dp_mem_util.svh"

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [dw-1:0] expected,
                               input logic [dw-1:0] actual);
        assert (actual === expected) else begin
            report_failure($sformatf("FAILED %s, %s: expected %h, actual %h",
                                     test_name, what, expected, actual));
        end
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        report_failure($sformatf("Timeout: tests still running after %0d clock cycles",
                                 watchdog_cycles));
    end

    initial begin
        mem_addr_t     addr;
        mem_addr_t     addr_b;
        logic [dw-1:0] data_a;
        logic [dw-1:0] data_b;
        logic [dw-1:0] old_word;
        logic [dw-1:0] rd_a;
        logic [dw-1:0] rd_b;
        mem_sel_t      sel_a;
        mem_sel_t      sel_b;
        logic          wr_a;
        logic          wr_b;
        int            edges_a;
        int            edges_b;

        lfsr_state = lfsr_seed;
        rst = 1'b1;
        for (int p = 0; p < 2; p++) begin
            cyc[p] = 1'b0;
            stb[p] = 1'b0;
            we[p] = 1'b0;
            adr[p] = '0;
            dat_w[p].word = '0;
            sel[p] = '0;
        end

        // Five edges in reset, two more after release.
        test_name = "reset_idle";
        for (int i = 0; i < 7; i++) begin
            @(posedge clk);
            #1;
            check_value("a_ack", '0, dw'(ack[0]));
            check_value("b_ack", '0, dw'(ack[1]));
            check_value("a_dat_r", '0, dat_r[0].word);
            check_value("b_dat_r", '0, dat_r[1].word);
            if (i == 4) begin
                #1;
                rst = 1'b0;
            end
        end

        // The array has no reset, so every word gets a known value first.
        test_name = "fill";
        for (int a = 0; a < depth; a++) begin
            model_mem[a] = rand_word();
        end
        for (int a = 0; a < depth / 2; a++) begin
            fork
                bus_xfer(0, 1'b1, mem_addr_t'(a), model_mem[a], '1, rd_a, edges_a);
                bus_xfer(1, 1'b1, mem_addr_t'(a + depth / 2), model_mem[a + depth / 2], '1,
                         rd_b, edges_b);
            join
        end

        test_name = "word_rw";
        for (int i = 0; i < n_word; i++) begin
            addr = mem_addr_t'(rand_bits(aw));
            data_a = rand_word();
            port_op(0, 1'b1, addr, data_a, '1);
            port_op(0, 1'b0, addr, '0, '1);
        end

        test_name = "byte_lanes";
        for (int i = 0; i < n_byte; i++) begin
            addr = mem_addr_t'(rand_bits(aw));
            data_a = rand_word();
            sel_a = rand_sel();
            port_op(0, 1'b1, addr, data_a, sel_a);
            port_op(0, 1'b0, addr, '0, '1);
        end

        // Both ports, reads and writes, each from idle.
        test_name = "latency";
        for (int i = 0; i < n_lat; i++) begin
            addr = mem_addr_t'(rand_bits(aw));
            data_a = rand_word();
            sel_a = rand_sel();
            port_op(i % 2, 1'((i / 2) % 2), addr, data_a, sel_a);
        end

        test_name = "dual_random";
        for (int i = 0; i < n_dual; i++) begin
            wr_a = 1'(rand_bits(1));
            addr = mem_addr_t'(rand_bits(aw - 1));
            data_a = rand_word();
            sel_a = rand_sel();
            wr_b = 1'(rand_bits(1));
            addr_b = mem_addr_t'(rand_bits(aw - 1));
            addr_b[aw-1] = 1'b1;
            data_b = rand_word();
            sel_b = rand_sel();
            fork
                port_op(0, wr_a, addr, data_a, sel_a);
                port_op(1, wr_b, addr_b, data_b, sel_b);
            join
        end

        test_name = "collision";
        for (int i = 0; i < n_coll; i++) begin
            addr = mem_addr_t'(rand_bits(aw));
            data_a = rand_word();
            data_b = rand_word();
            sel_a = rand_sel();
            sel_b = rand_sel();
            // Lowest lane of A is always shared.
            sel_b = sel_b | (sel_a & (-sel_a));
            old_word = model_mem[addr];
            fork
                bus_xfer(0, 1'b1, addr, data_a, sel_a, rd_a, edges_a);
                bus_xfer(1, 1'b1, addr, data_b, sel_b, rd_b, edges_b);
            join
            check_value("a_dat_r old word", old_word, rd_a);
            check_value("b_dat_r old word", old_word, rd_b);
            check_value("a edges to ack", dw'(6), dw'(edges_a));
            check_value("b edges to ack", dw'(6), dw'(edges_b));
            model_mem[addr] = merge_lanes(merge_lanes(old_word, data_a, sel_a), data_b, sel_b);
            port_op(0, 1'b0, addr, '0, '1);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
